/* sim/capture_stim.txt */
# control_word(hex) burst_len tready_pct chirp_init upper_kind lower_kind dac_iq(hex)
# kinds: 0 adc iq, 1 dac iq, 2 sample count, 3 global count
00000000 40 100 0 0 0 12345678
00000010 32 100 0 1 0 a5a5f00d
00000001 24 90 0 0 1 0badcafe
00000032 45 75 1 3 2 00010002
00000023 20 50 0 2 3 7fff8000
00000031 50 60 0 3 1 c0de1234
00000013 16 40 1 1 3 55aa55aa
00000002 30 100 1 0 2 00000000
00000020 8 35 0 2 0 ffffffff
00000033 12 80 0 3 3 13572468
00000011 28 55 1 1 1 fedcba98
00000022 36 45 0 2 2 01234567
ffffffcc 44 25 0 0 0 89abcdef
deadbe1e 18 70 1 1 2 3c3c3c3c
12345603 26 30 0 0 3 80000001
a5a5a5e7 50 25 1 2 3 0f0f0f0f
0000003d 10 95 0 3 1 deadbeef
00000012 4 50 0 1 2 11112222
00000021 48 65 1 2 1 aaaa5555
00000030 38 85 0 3 0 00ff00ff
00000003 22 100 1 0 3 ff00ff00
00000003 3 40 0 0 3 76543210
00000010 34 30 0 1 0 2468ace0
00000031 14 50 1 3 1 9abcdef0
00000000 52 100 1 0 0 cafef00d
00000023 42 35 0 2 3 b00bb00b

/* verilog.f */
rtl/capture_pkg.sv
rtl/route_config.sv
rtl/capture_framer.sv
rtl/sample_fifo.sv
rtl/axis_packer.sv
rtl/adc_capture_top.sv
sim/capture_checker.sv
sim/tb_adc_capture.sv

/* Makefile */
# Verilator build and run for the ADC capture testbench

VERILATOR ?= verilator
TOP ?= tb_adc_capture
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= test passed
VFLAGS ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/tb_adc_capture.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_adc_capture;

  localparam int TIMEOUT_CYCLES = 4000; // per trailer wait
  localparam int MIN_BURST = 3;
  localparam int MAX_BURST = 52; // packet stays under FIFO_DEPTH

  logic clk_245_76MHz;
  logic cpu_reset;
  logic adc_enable;
  logic chirp_init;
  logic [31:0] control_word;
  logic sample_valid;
  logic [31:0] ramp; // adc I/Q as one 32-bit count
  logic [capture_pkg::SAMPLE_W-1:0] adc_i;
  logic [capture_pkg::SAMPLE_W-1:0] adc_q;
  logic [capture_pkg::SAMPLE_W-1:0] dac_i;
  logic [capture_pkg::SAMPLE_W-1:0] dac_q;
  logic axis_tready;
  logic [capture_pkg::WORD_W-1:0] axis_tdata;
  logic axis_tvalid;
  logic axis_tlast;
  logic fifo_overflow;

  logic [1:0] exp_upper;
  logic [1:0] exp_lower;
  logic [31:0] dac_const;
  int tready_pct; // chance of ready per cycle
  int error_count;
  int packet_count;
  int burst_cnt;
  int stim_errors;
  logic timed_out;

  assign adc_i = ramp[31:16]; // I high
  assign adc_q = ramp[15:0];
  assign dac_i = dac_const[31:16];
  assign dac_q = dac_const[15:0];

  initial begin
    clk_245_76MHz = 1'b0;
    forever #5 clk_245_76MHz = ~clk_245_76MHz;
  end

  adc_capture_top u_adc_capture_top (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset (cpu_reset),
    .adc_enable (adc_enable),
    .chirp_init (chirp_init),
    .control_word (control_word),
    .adc_i (adc_i),
    .adc_q (adc_q),
    .sample_valid (sample_valid),
    .dac_i (dac_i),
    .dac_q (dac_q),
    .axis_tready (axis_tready),
    .axis_tdata (axis_tdata),
    .axis_tvalid (axis_tvalid),
    .axis_tlast (axis_tlast),
    .fifo_overflow (fifo_overflow)
  );

  capture_checker u_capture_checker (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset (cpu_reset),
    .axis_tdata (axis_tdata),
    .axis_tvalid (axis_tvalid),
    .axis_tlast (axis_tlast),
    .axis_tready (axis_tready),
    .fifo_overflow (fifo_overflow),
    .exp_upper (exp_upper),
    .exp_lower (exp_lower),
    .dac_const (dac_const),
    .error_count (error_count),
    .packet_count (packet_count)
  );

  // falling edge, then new ramp value and ready draw
  task automatic step_cycle();
    @(negedge clk_245_76MHz);
    ramp = ramp + 1'b1;
    axis_tready = int'($urandom % 100) < tready_pct;
  endtask

  task automatic wait_packet(input int target, output logic ok);
    int waited;
    waited = 0;
    while (packet_count < target && waited < TIMEOUT_CYCLES) begin
      step_cycle();
      waited++;
    end
    ok = (packet_count >= target);
  endtask

  initial begin
    int fd;
    int n;
    int len;
    int pct;
    int chirp;
    int up;
    int lo;
    string line;
    logic [31:0] cw;
    logic [31:0] dac;
    logic ok;
    void'($urandom(68));
    cpu_reset = 1'b1;
    adc_enable = 1'b0;
    chirp_init = 1'b0;
    control_word = '0;
    sample_valid = 1'b1; // always valid
    ramp = '0;
    axis_tready = 1'b0;
    exp_upper = '0;
    exp_lower = '0;
    dac_const = '0;
    tready_pct = 100;
    burst_cnt = 0;
    stim_errors = 0;
    timed_out = 1'b0;
    repeat (16) step_cycle();
    cpu_reset = 1'b0;
    fd = $fopen("sim/capture_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file sim/capture_stim.txt");
      stim_errors++;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        line = "";
        if ($fgets(line, fd) == 0) break;
        if (line.len() < 2 || line[0] == "#") continue; // blank or comment
        n = $sscanf(line, "%h %d %d %d %d %d %h", cw, len, pct, chirp, up, lo, dac);
        if (n != 7 || len < MIN_BURST || len > MAX_BURST) begin
          $display("bad stimulus line skipped: %s", line);
          stim_errors++;
          continue;
        end
        control_word = cw;
        exp_upper = up[1:0];
        exp_lower = lo[1:0];
        dac_const = dac;
        tready_pct = pct;
        step_cycle(); // selects settle
        step_cycle();
        if (chirp != 0) begin
          chirp_init = 1'b1; // restarts hold-off
          step_cycle();
          chirp_init = 1'b0;
        end
        adc_enable = 1'b1;
        repeat (len) step_cycle();
        adc_enable = 1'b0;
        burst_cnt++;
        wait_packet(burst_cnt, ok);
        if (!ok) begin
          $display("timeout waiting for the trailer of burst %0d", burst_cnt);
          timed_out = 1'b1;
        end
      end
      $fclose(fd);
    end
    repeat (20) step_cycle(); // catch stray words
    $display("errors %0d, stimulus errors %0d, timeouts %0d, packets %0d of %0d bursts",
             error_count, stim_errors, timed_out, packet_count, burst_cnt);
    if (error_count == 0 && stim_errors == 0 && !timed_out && burst_cnt > 0 &&
        packet_count == burst_cnt) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/capture_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module capture_checker (
  input wire logic clk_245_76MHz,
  input wire logic cpu_reset,
  input wire logic [capture_pkg::WORD_W-1:0] axis_tdata,
  input wire logic axis_tvalid,
  input wire logic axis_tlast,
  input wire logic axis_tready,
  input wire logic fifo_overflow,
  input wire logic [1:0] exp_upper, // lane kinds from the stim file
  input wire logic [1:0] exp_lower,
  input wire logic [31:0] dac_const, // expected DAC I/Q pair
  output int error_count,
  output int packet_count
);

  localparam int HALF = capture_pkg::WORD_W / 2;

  logic [HALF-1:0] upper_lane;
  logic [HALF-1:0] lower_lane;
  logic in_packet; // header seen, trailer not yet
  int pos; // word index inside the packet
  logic [HALF-1:0] hdr_smp; // header sample count
  logic [HALF-1:0] hdr_glb;
  logic [HALF-1:0] prev_trl_glb; // global count of the last trailer
  logic [HALF-1:0] prev_upper; // previous data word lanes
  logic [HALF-1:0] prev_lower;
  logic stalled; // valid without ready last cycle
  logic [capture_pkg::WORD_W-1:0] held_data;
  logic held_last;
  logic ovf_seen;

  // one lane of a data word against its routed source
  task automatic check_lane(input logic [1:0] kind, input logic [HALF-1:0] val,
                            input logic [HALF-1:0] prev, input string name);
    case (kind)
      capture_pkg::ROUTE_ADC_IQ: begin
        if (pos > 1 && val != prev + 1'b1) begin // ramp step of one
          $display("Error: %s expected 0x%h got 0x%h", name, prev + 1'b1, val);
          error_count++;
        end
      end
      capture_pkg::ROUTE_DAC_IQ: begin
        if (val != dac_const) begin
          $display("Error: %s expected 0x%h got 0x%h", name, dac_const, val);
          error_count++;
        end
      end
      capture_pkg::ROUTE_SAMPLE_COUNT: begin
        if (val != hdr_smp + HALF'(pos)) begin
          $display("Error: %s expected 0x%h got 0x%h", name, hdr_smp + HALF'(pos), val);
          error_count++;
        end
      end
      default: begin
        if (val <= prev) begin // global count never stalls
          $display("Error: %s 0x%h not above 0x%h", name, val, prev);
          error_count++;
        end
      end
    endcase
  endtask

  // one accepted beat
  task automatic take_word();
    upper_lane = axis_tdata[capture_pkg::WORD_W-1:HALF];
    lower_lane = axis_tdata[HALF-1:0];
    if (!in_packet) begin
      // header
      if (axis_tlast) begin
        $display("Error: axis_tlast expected 0x0 got 0x1");
        error_count++;
      end
      if (upper_lane <= prev_trl_glb) begin
        $display("Error: axis_tdata header global 0x%h not above 0x%h", upper_lane, prev_trl_glb);
        error_count++;
      end
      hdr_smp = lower_lane;
      hdr_glb = upper_lane;
      prev_upper = upper_lane; // first global lane compares to header
      prev_lower = upper_lane;
      pos = 1;
      in_packet = 1'b1;
    end else if (axis_tlast) begin
      // trailer
      if (lower_lane - hdr_smp != HALF'(pos)) begin
        $display("Error: axis_tdata sample span expected 0x%h got 0x%h",
                 HALF'(pos), lower_lane - hdr_smp);
        error_count++;
      end
      if (upper_lane <= prev_trl_glb || upper_lane <= hdr_glb) begin
        $display("Error: axis_tdata trailer global 0x%h not above 0x%h", upper_lane, hdr_glb);
        error_count++;
      end
      prev_trl_glb = upper_lane;
      in_packet = 1'b0;
      packet_count++;
    end else begin
      check_lane(exp_upper, upper_lane, prev_upper, "axis_tdata upper lane");
      check_lane(exp_lower, lower_lane, prev_lower, "axis_tdata lower lane");
      prev_upper = upper_lane;
      prev_lower = lower_lane;
      pos++;
    end
  endtask

  always @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      error_count = 0;
      packet_count = 0;
      in_packet = 1'b0;
      pos = 0;
      prev_trl_glb = '0;
      stalled = 1'b0;
      ovf_seen = 1'b0;
    end else begin
      if (fifo_overflow && !ovf_seen) begin
        $display("fifo_overflow went high, a word was dropped");
        error_count++;
        ovf_seen = 1'b1; // report once
      end
      if (stalled) begin // stage must hold under back-pressure
        if (!axis_tvalid) begin
          $display("Error: axis_tvalid expected 0x1 got 0x0");
          error_count++;
        end
        if (axis_tdata != held_data) begin
          $display("Error: axis_tdata expected 0x%h got 0x%h", held_data, axis_tdata);
          error_count++;
        end
        if (axis_tlast != held_last) begin
          $display("Error: axis_tlast expected 0x%h got 0x%h", held_last, axis_tlast);
          error_count++;
        end
      end
      stalled = axis_tvalid && !axis_tready;
      held_data = axis_tdata;
      held_last = axis_tlast;
      if (axis_tvalid && axis_tready) take_word();
    end
  end

endmodule

`default_nettype wire

/* rtl/adc_capture_top.sv */
`timescale 1ns/100ps
`default_nettype none

module adc_capture_top (
  input wire logic clk_245_76MHz,
  input wire logic cpu_reset,
  input wire logic adc_enable,
  input wire logic chirp_init,
  input wire logic [31:0] control_word, // lane routing fields
  input wire logic [capture_pkg::SAMPLE_W-1:0] adc_i,
  input wire logic [capture_pkg::SAMPLE_W-1:0] adc_q,
  input wire logic sample_valid,
  input wire logic [capture_pkg::SAMPLE_W-1:0] dac_i,
  input wire logic [capture_pkg::SAMPLE_W-1:0] dac_q,
  input wire logic axis_tready,
  output logic [capture_pkg::WORD_W-1:0] axis_tdata,
  output logic axis_tvalid,
  output logic axis_tlast,
  output logic fifo_overflow
);

  capture_pkg::route_sel_t lower_sel;
  capture_pkg::route_sel_t upper_sel;

  logic fifo_push; // framer side
  logic fifo_full;
  capture_pkg::fifo_entry_t wr_entry;

  logic fifo_pop; // packer side
  logic fifo_empty;
  capture_pkg::fifo_entry_t rd_entry;

  route_config u_route_config (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset (cpu_reset),
    .control_word (control_word),
    .lower_sel (lower_sel),
    .upper_sel (upper_sel)
  );

  capture_framer u_capture_framer (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset (cpu_reset),
    .adc_enable (adc_enable),
    .chirp_init (chirp_init),
    .sample_valid (sample_valid),
    .adc_i (adc_i),
    .adc_q (adc_q),
    .dac_i (dac_i),
    .dac_q (dac_q),
    .lower_sel (lower_sel),
    .upper_sel (upper_sel),
    .push (fifo_push),
    .entry (wr_entry)
  );

  sample_fifo u_sample_fifo (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset (cpu_reset),
    .push (fifo_push),
    .wr_entry (wr_entry),
    .full (fifo_full),
    .pop (fifo_pop),
    .rd_entry (rd_entry),
    .empty (fifo_empty),
    .overflow (fifo_overflow)
  );

  axis_packer u_axis_packer (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset (cpu_reset),
    .rd_entry (rd_entry),
    .empty (fifo_empty),
    .pop (fifo_pop),
    .tdata (axis_tdata),
    .tvalid (axis_tvalid),
    .tlast (axis_tlast),
    .tready (axis_tready)
  );

endmodule

`default_nettype wire

/* rtl/axis_packer.sv */
`timescale 1ns/100ps
`default_nettype none

module axis_packer (
  input wire logic clk_245_76MHz,
  input wire logic cpu_reset,
  input wire capture_pkg::fifo_entry_t rd_entry,
  input wire logic empty,
  output logic pop,
  output capture_pkg::word_t tdata,
  output logic tvalid,
  output logic tlast,
  input wire logic tready
);

  logic stage_free; // stage empty or draining this cycle

  assign stage_free = !tvalid || tready;
  assign pop = stage_free && !empty; // refill on the consume cycle

  // control bits of the output stage
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      tvalid <= 1'b0;
      tlast <= 1'b0;
    end else if (pop) begin
      tvalid <= 1'b1;
      tlast <= rd_entry.last;
    end else if (tready) begin
      tvalid <= 1'b0; // drained with nothing queued
      tlast <= 1'b0;
    end
  end

  // payload only moves on a pop, so it holds under back-pressure
  always_ff @(posedge clk_245_76MHz) begin
    if (pop) tdata <= rd_entry.data;
  end

endmodule

`default_nettype wire

/* rtl/sample_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module sample_fifo (
  input wire logic clk_245_76MHz,
  input wire logic cpu_reset,
  input wire logic push,
  input wire capture_pkg::fifo_entry_t wr_entry,
  output logic full,
  input wire logic pop,
  output capture_pkg::fifo_entry_t rd_entry,
  output logic empty,
  output logic overflow // sticky until reset
);

  capture_pkg::fifo_entry_t mem [capture_pkg::FIFO_DEPTH];

  // extra msb tells full from empty
  logic [capture_pkg::FIFO_AW:0] wr_ptr;
  logic [capture_pkg::FIFO_AW:0] rd_ptr;
  logic wr_en;
  logic rd_en;

  assign empty = (wr_ptr == rd_ptr);
  assign full = (wr_ptr[capture_pkg::FIFO_AW] != rd_ptr[capture_pkg::FIFO_AW]) &&
                (wr_ptr[capture_pkg::FIFO_AW-1:0] == rd_ptr[capture_pkg::FIFO_AW-1:0]);

  assign wr_en = push && !full; // push on full is lost
  assign rd_en = pop && !empty;

  always_ff @(posedge clk_245_76MHz) begin
    if (wr_en) mem[wr_ptr[capture_pkg::FIFO_AW-1:0]] <= wr_entry;
  end

  // fall-through read of the queue head
  assign rd_entry = mem[rd_ptr[capture_pkg::FIFO_AW-1:0]];

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      overflow <= 1'b0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      if (push && full) overflow <= 1'b1; // word dropped
    end
  end

endmodule

`default_nettype wire

/* rtl/capture_framer.sv */
`timescale 1ns/100ps
`default_nettype none

module capture_framer (
  input wire logic clk_245_76MHz,
  input wire logic cpu_reset,
  input wire logic adc_enable,
  input wire logic chirp_init, // restarts the hold-off
  input wire logic sample_valid,
  input wire logic [capture_pkg::SAMPLE_W-1:0] adc_i,
  input wire logic [capture_pkg::SAMPLE_W-1:0] adc_q,
  input wire logic [capture_pkg::SAMPLE_W-1:0] dac_i,
  input wire logic [capture_pkg::SAMPLE_W-1:0] dac_q,
  input wire capture_pkg::route_sel_t lower_sel,
  input wire capture_pkg::route_sel_t upper_sel,
  output logic push,
  output capture_pkg::fifo_entry_t entry
);

  logic enable_r; // adc_enable one cycle late
  logic gate; // enable held back by the hold-off
  logic [capture_pkg::HOLD_W-1:0] hold_cnt;
  logic hold_done; // counter at zero
  logic first; // header cycle
  logic last; // trailer cycle

  capture_pkg::lane_t sample_cnt; // pushes since reset
  capture_pkg::lane_t glbl_cnt; // free running
  capture_pkg::lane_t adc_iq;
  capture_pkg::lane_t dac_iq;
  capture_pkg::lane_t lower_lane;
  capture_pkg::lane_t upper_lane;

  // four-way lane source mux
  function automatic capture_pkg::lane_t pick_lane(
    input capture_pkg::route_sel_t sel,
    input capture_pkg::lane_t adc_val,
    input capture_pkg::lane_t dac_val,
    input capture_pkg::lane_t smp_val,
    input capture_pkg::lane_t glb_val
  );
    capture_pkg::lane_t lane;
    unique case (sel)
      capture_pkg::ROUTE_ADC_IQ: lane = adc_val;
      capture_pkg::ROUTE_DAC_IQ: lane = dac_val;
      capture_pkg::ROUTE_SAMPLE_COUNT: lane = smp_val;
      capture_pkg::ROUTE_GLOBAL_COUNT: lane = glb_val;
    endcase
    return lane;
  endfunction

  assign hold_done = (hold_cnt == '0);

  // enable sync and gate
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      enable_r <= 1'b0;
      gate <= 1'b0;
    end else begin
      enable_r <= adc_enable;
      if (hold_done) gate <= enable_r; // frozen while counting
    end
  end

  // hold-off reloads on chirp start or falling enable
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      hold_cnt <= '0;
    end else if (chirp_init) begin
      hold_cnt <= capture_pkg::HOLD_W'(capture_pkg::DDS_LATENCY);
    end else if (enable_r && !adc_enable) begin
      hold_cnt <= capture_pkg::HOLD_W'(capture_pkg::DDS_LATENCY);
    end else if (!hold_done) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  // header pulse lines up with first gated cycle
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      first <= 1'b0;
    end else begin
      first <= hold_done && enable_r && !gate;
    end
  end

  assign last = hold_done && gate && !enable_r; // gate drops next cycle
  assign push = gate && sample_valid;

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      sample_cnt <= '0;
      glbl_cnt <= '0;
    end else begin
      glbl_cnt <= glbl_cnt + 1'b1;
      if (push) sample_cnt <= sample_cnt + 1'b1;
    end
  end

  assign adc_iq = {adc_i, adc_q}; // I high
  assign dac_iq = {dac_i, dac_q};

  assign lower_lane = pick_lane(lower_sel, adc_iq, dac_iq, sample_cnt, glbl_cnt);
  assign upper_lane = pick_lane(upper_sel, adc_iq, dac_iq, sample_cnt, glbl_cnt);

  // header and trailer carry counts while data words carry routed lanes
  always_comb begin
    if (first || last) begin
      entry.data = {glbl_cnt, sample_cnt};
    end else begin
      entry.data = {upper_lane, lower_lane};
    end
    entry.last = last;
  end

endmodule

`default_nettype wire

/* rtl/route_config.sv */
`timescale 1ns/100ps
`default_nettype none

module route_config (
  input wire logic clk_245_76MHz,
  input wire logic cpu_reset,
  input wire logic [31:0] control_word,
  output capture_pkg::route_sel_t lower_sel,
  output capture_pkg::route_sel_t upper_sel
);

  localparam int SEL_W = $bits(capture_pkg::route_sel_t); // 2 bits per field

  logic [SEL_W-1:0] lower_field; // raw bits before the register
  logic [SEL_W-1:0] upper_field;

  assign lower_field = control_word[capture_pkg::ROUTE_LOWER_LSB +: SEL_W];
  assign upper_field = control_word[capture_pkg::ROUTE_UPPER_LSB +: SEL_W];

  // one cycle from control word to selects
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      lower_sel <= capture_pkg::ROUTE_ADC_IQ; // adc samples on both lanes
      upper_sel <= capture_pkg::ROUTE_ADC_IQ;
    end else begin
      lower_sel <= capture_pkg::route_sel_t'(lower_field);
      upper_sel <= capture_pkg::route_sel_t'(upper_field);
    end
  end

endmodule

`default_nettype wire

/* rtl/capture_pkg.sv */
`default_nettype none

package capture_pkg;

  localparam int SAMPLE_W = 16; // one I or Q sample
  localparam int LANE_W = 32; // I/Q pair, I in upper half
  localparam int WORD_W = 64; // two lanes, upper lane high

  localparam int DDS_LATENCY = 2; // gate hold-off in cycles
  localparam int HOLD_W = $clog2(DDS_LATENCY + 1); // hold-off counter width

  localparam int FIFO_DEPTH = 64;
  localparam int FIFO_AW = 6; // log2 of FIFO_DEPTH

  // lane select fields in the control word
  localparam int ROUTE_LOWER_LSB = 0;
  localparam int ROUTE_UPPER_LSB = 4;

  typedef enum logic [1:0] {
    ROUTE_ADC_IQ = 2'd0,
    ROUTE_DAC_IQ = 2'd1,
    ROUTE_SAMPLE_COUNT = 2'd2,
    ROUTE_GLOBAL_COUNT = 2'd3
  } route_sel_t;

  typedef logic [LANE_W-1:0] lane_t;
  typedef logic [WORD_W-1:0] word_t;

  // one FIFO slot, word plus packet end marker
  typedef struct packed {
    word_t data;
    logic last;
  } fifo_entry_t;

endpackage

`default_nettype wire
